// File: hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and bus address width
`define CPU_WIDTH 32

// register file size, r15 is pc, r14 link, r13 sp
`define CPU_NREGS 16

// register index width
`define CPU_RSEL_W 4

`endif

// File: hdl/cpu_pkg.sv
// instruction word layout
//   31..30  cond flag (cond_t)
//   29      cond value, the flag must equal this
//   28      cond enable, 0 means always execute
//   27      call, jump to ic[26:0] and link into r14
//   26..24  kind (inst_t)
//   23..20  rd
//   19..16  ra
//   15..12  rb
//   11..7   alu op (alu_op_t)
//   15..0   literal for ldl0, ldl and ldh
package cpu_pkg;

   // one instruction takes all four phases in order
   typedef enum logic [1:0] {
      PH_FETCH = 2'd0,
      PH_EXEC  = 2'd1,
      PH_MEM   = 2'd2,
      PH_WB    = 2'd3
   } phase_t;

   typedef enum logic [2:0] {
      I_NOP  = 3'd0,
      I_LD   = 3'd1,
      I_ST   = 3'd2,
      I_MOV  = 3'd3,
      I_LDL0 = 3'd4,
      I_LDL  = 3'd5,
      I_LDH  = 3'd6,
      I_OP   = 3'd7
   } inst_t;

   typedef enum logic [1:0] {
      C_S = 2'd0,
      C_C = 2'd1,
      C_Z = 2'd2,
      C_V = 2'd3
   } cond_t;

   // codes 14..31 are unused, they give zero
   typedef enum logic [4:0] {
      ADD   = 5'd0,
      ADC   = 5'd1,
      SUB   = 5'd2,
      SBC   = 5'd3,
      AND   = 5'd4,
      OR    = 5'd5,
      XOR   = 5'd6,
      NOT   = 5'd7,
      SHL   = 5'd8,
      SHR   = 5'd9,
      ROL   = 5'd10,
      ROR   = 5'd11,
      CMP   = 5'd12,
      PASSB = 5'd13
   } alu_op_t;

endpackage

// File: hdl/phase_sched.sv
`timescale 1ns/1ns

module phase_sched
   import cpu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   output phase_t     phase,
   output logic [2:0] clk_stat
);

   logic done_tgl;   // flips once per retired instruction

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         phase    <= PH_FETCH;
         done_tgl <= 1'b0;
      end
      else
      begin
         case (phase)
            PH_FETCH: phase <= PH_EXEC;
            PH_EXEC:  phase <= PH_MEM;
            PH_MEM:   phase <= PH_WB;
            default:
            begin
               phase    <= PH_FETCH;
               done_tgl <= ~done_tgl;   // end of writeback
            end
         endcase
      end
   end

   assign clk_stat = {done_tgl, phase};

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module reg_file
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   inc_pc,   // execute phase
   input  logic                   wen,      // writeback phase
   input  logic                   link,
   input  logic [`CPU_RSEL_W-1:0] wa,
   input  logic [`CPU_WIDTH-1:0]  din,
   input  logic [`CPU_RSEL_W-1:0] ra,
   input  logic [`CPU_RSEL_W-1:0] rb,
   input  logic [`CPU_RSEL_W-1:0] rd,
   output logic [`CPU_WIDTH-1:0]  da,
   output logic [`CPU_WIDTH-1:0]  db,
   output logic [`CPU_WIDTH-1:0]  dd,
   input  logic [`CPU_RSEL_W-1:0] rt,
   output logic [`CPU_WIDTH-1:0]  dt,
   output logic [`CPU_WIDTH-1:0]  pc
);

   localparam int PC_IDX = `CPU_NREGS - 1;
   localparam int LR_IDX = `CPU_NREGS - 2;

   logic [`CPU_WIDTH-1:0] regs [`CPU_NREGS];
   logic [`CPU_WIDTH-1:0] pc_next;

   assign pc      = regs[PC_IDX];
   assign pc_next = pc + `CPU_WIDTH'd1;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `CPU_NREGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         if (inc_pc)
            regs[PC_IDX] <= pc_next;
         if (link)
            regs[LR_IDX] <= pc_next;   // return address
         // later in the block so a write to r15 wins
         if (wen)
            regs[wa] <= din;
      end
   end

   // combinational reads
   assign da = regs[ra];
   assign db = regs[rb];
   assign dd = regs[rd];
   assign dt = regs[rt];   // view port for the testbench

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module alu
   import cpu_pkg::*;
(
   input  alu_op_t                op,
   input  logic [`CPU_WIDTH-1:0]  a,
   input  logic [`CPU_WIDTH-1:0]  b,
   input  logic                   ci,
   output logic [`CPU_WIDTH-1:0]  res,
   output logic                   co,
   output logic                   zo,
   output logic                   so,
   output logic                   vo
);

   localparam int MSB = `CPU_WIDTH - 1;

   logic                 add_cin;
   logic                 sub_cin;
   logic [`CPU_WIDTH:0]  add_sum;   // extra bit is carry out
   logic [`CPU_WIDTH:0]  sub_sum;
   logic                 add_v;
   logic                 sub_v;
   logic [MSB:0]         flag_val;  // value z and s are taken from

   // subtract is a + ~b + 1, so c set means no borrow
   assign add_cin = (op == ADC) ? ci : 1'b0;
   assign sub_cin = (op == SBC) ? ci : 1'b1;

   assign add_sum = {1'b0, a} + {1'b0, b} + {{`CPU_WIDTH{1'b0}}, add_cin};
   assign sub_sum = {1'b0, a} + {1'b0, ~b} + {{`CPU_WIDTH{1'b0}}, sub_cin};

   // signed overflow
   assign add_v = (a[MSB] == b[MSB]) && (add_sum[MSB] != a[MSB]);
   assign sub_v = (a[MSB] != b[MSB]) && (sub_sum[MSB] != a[MSB]);

   always_comb
   begin
      res = '0;
      co  = 1'b0;
      vo  = 1'b0;
      case (op)
         ADD, ADC:
         begin
            res = add_sum[MSB:0];
            co  = add_sum[`CPU_WIDTH];
            vo  = add_v;
         end
         SUB, SBC:
         begin
            res = sub_sum[MSB:0];
            co  = sub_sum[`CPU_WIDTH];
            vo  = sub_v;
         end
         CMP:
         begin
            res = a;   // only the flags change
            co  = sub_sum[`CPU_WIDTH];
            vo  = sub_v;
         end
         AND:   res = a & b;
         OR:    res = a | b;
         XOR:   res = a ^ b;
         NOT:   res = ~a;
         PASSB: res = b;
         // single bit shifts, c gets the bit shifted out
         SHL:
         begin
            res = {a[MSB-1:0], 1'b0};
            co  = a[MSB];
         end
         SHR:
         begin
            res = {1'b0, a[MSB:1]};
            co  = a[0];
         end
         ROL:
         begin
            res = {a[MSB-1:0], a[MSB]};
            co  = a[MSB];
         end
         ROR:
         begin
            res = {a[0], a[MSB:1]};
            co  = a[0];
         end
         default: res = '0;
      endcase
   end

   // compare sets z and s from the difference
   assign flag_val = (op == CMP) ? sub_sum[MSB:0] : res;
   assign zo       = (flag_val == '0);
   assign so       = flag_val[MSB];

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module instr_decode
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`CPU_WIDTH-1:0]  ic,
   input  logic                   flag_wen,
   input  logic                   c_in,
   input  logic                   z_in,
   input  logic                   s_in,
   input  logic                   v_in,
   output inst_t                  kind,
   output logic                   call,
   output logic                   ena,
   output alu_op_t                alu_op,
   output logic [`CPU_RSEL_W-1:0] ra,
   output logic [`CPU_RSEL_W-1:0] rb,
   output logic [`CPU_RSEL_W-1:0] rd,
   output logic [15:0]            lit,
   output logic                   flag_c
);

   cond_t cond_flag;
   logic  cond_value;
   logic  cond_en;
   logic  flag_s;
   logic  flag_z;
   logic  flag_v;
   logic  flag_sel;

   // field extraction
   assign cond_flag  = cond_t'(ic[31:30]);
   assign cond_value = ic[29];
   assign cond_en    = ic[28];
   assign call       = ic[27];
   assign kind       = inst_t'(ic[26:24]);
   assign rd         = ic[23:20];
   assign ra         = ic[19:16];
   assign rb         = ic[15:12];
   assign alu_op     = alu_op_t'(ic[11:7]);
   assign lit        = ic[15:0];

   // flags register, written by op at the writeback edge
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         {flag_c, flag_s, flag_z, flag_v} <= 4'b0000;
      end
      else if (flag_wen)
      begin
         {flag_c, flag_s, flag_z, flag_v} <= {c_in, s_in, z_in, v_in};
      end
   end

   always_comb
   begin
      case (cond_flag)
         C_S:     flag_sel = flag_s;
         C_C:     flag_sel = flag_c;
         C_Z:     flag_sel = flag_z;
         default: flag_sel = flag_v;
      endcase
   end

   assign ena = !cond_en || (flag_sel == cond_value);

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu
   import cpu_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   output logic [`CPU_WIDTH-1:0]  mbus_aout,
   output logic [`CPU_WIDTH-1:0]  mbus_dout,
   input  logic [`CPU_WIDTH-1:0]  mbus_din,
   output logic                   mbus_wen,
   input  logic [`CPU_RSEL_W-1:0] test_rsel,
   output logic [`CPU_WIDTH-1:0]  test_reg,
   output logic [2:0]             clk_stat
);

   phase_t                  phase;
   logic                    ph_fetch;
   logic                    ph_exec;
   logic                    ph_mem;
   logic                    ph_wb;

   logic [`CPU_WIDTH-1:0]   ir;        // instruction register
   logic [`CPU_WIDTH-1:0]   ld_data;   // data read by ld

   inst_t                   kind;
   logic                    call;
   logic                    ena;
   alu_op_t                 alu_op;
   logic [`CPU_RSEL_W-1:0]  ra;
   logic [`CPU_RSEL_W-1:0]  rb;
   logic [`CPU_RSEL_W-1:0]  rd;
   logic [15:0]             lit;
   logic                    flag_c;

   logic                    is_ld;
   logic                    is_st;
   logic                    is_op;
   logic                    has_wb;

   logic [`CPU_WIDTH-1:0]   da;
   logic [`CPU_WIDTH-1:0]   db;
   logic [`CPU_WIDTH-1:0]   dd;
   logic [`CPU_WIDTH-1:0]   pc;

   logic [`CPU_WIDTH-1:0]   alu_res;
   logic                    c_res;
   logic                    z_res;
   logic                    s_res;
   logic                    v_res;

   logic [`CPU_WIDTH-1:0]   inst_res;
   logic [`CPU_WIDTH-1:0]   wb_data;
   logic [`CPU_RSEL_W-1:0]  wb_addr;
   logic                    wb_en;
   logic                    link_en;
   logic                    flag_wen;

   phase_sched i_sched
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .phase    (phase),
      .clk_stat (clk_stat)
   );

   assign ph_fetch = (phase == PH_FETCH);
   assign ph_exec  = (phase == PH_EXEC);
   assign ph_mem   = (phase == PH_MEM);
   assign ph_wb    = (phase == PH_WB);

   // after reset the ir holds a nop
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ir <= '0;
      else if (ph_fetch)
         ir <= mbus_din;
   end

   instr_decode i_decode
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .ic       (ir),
      .flag_wen (flag_wen),
      .c_in     (c_res),
      .z_in     (z_res),
      .s_in     (s_res),
      .v_in     (v_res),
      .kind     (kind),
      .call     (call),
      .ena      (ena),
      .alu_op   (alu_op),
      .ra       (ra),
      .rb       (rb),
      .rd       (rd),
      .lit      (lit),
      .flag_c   (flag_c)
   );

   // a call ignores the kind field
   assign is_ld  = !call && (kind == I_LD);
   assign is_st  = !call && (kind == I_ST);
   assign is_op  = !call && (kind == I_OP);
   assign has_wb = call || ((kind != I_NOP) && (kind != I_ST));

   alu i_alu
   (
      .op  (alu_op),
      .a   (da),
      .b   (db),
      .ci  (flag_c),
      .res (alu_res),
      .co  (c_res),
      .zo  (z_res),
      .so  (s_res),
      .vo  (v_res)
   );

   always_ff @(posedge clk)
   begin
      if (ph_mem && is_ld)
         ld_data <= mbus_din;
   end

   always_comb
   begin
      case (kind)
         I_LD:    inst_res = ld_data;
         I_MOV:   inst_res = da;
         I_LDL0:  inst_res = {16'd0, lit};
         I_LDL:   inst_res = {dd[31:16], lit};
         I_LDH:   inst_res = {lit, dd[15:0]};
         I_OP:    inst_res = alu_res;
         default: inst_res = '0;
      endcase
   end

   assign wb_data = call ? {5'd0, ir[26:0]} : inst_res;   // call target
   assign wb_addr = call ? `CPU_RSEL_W'(`CPU_NREGS - 1) : rd;

   assign wb_en    = ph_wb && ena && has_wb;
   assign link_en  = ph_exec && ena && call;
   assign flag_wen = ph_wb && ena && is_op;

   reg_file i_regs
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .inc_pc (ph_exec),
      .wen    (wb_en),
      .link   (link_en),
      .wa     (wb_addr),
      .din    (wb_data),
      .ra     (ra),
      .rb     (rb),
      .rd     (rd),
      .da     (da),
      .db     (db),
      .dd     (dd),
      .rt     (test_rsel),
      .dt     (test_reg),
      .pc     (pc)
   );

   // bus, data address only in the memory phase
   assign mbus_aout = (ph_mem && (is_ld || is_st)) ? da : pc;
   assign mbus_dout = dd;
   assign mbus_wen  = ph_mem && ena && is_st;

endmodule

// File: dv/cpu_assert.sv
`timescale 1ns/1ns

module cpu_assert
   import cpu_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input logic [2:0]  clk_stat,
   input logic [31:0] mbus_aout,
   input logic [31:0] mbus_dout,
   input logic        mbus_wen,
   input logic [3:0]  test_rsel,
   input logic [31:0] test_reg
);

   // values the program builds, from the ISA rules
   localparam logic [31:0] R2          = {16'habcd, 16'h1234};   // ldl0 then ldh
   localparam logic [31:0] R4          = 32'h0000_0ff0;
   localparam logic [31:0] R5          = R2 + R4;
   localparam logic [31:0] R6          = R4 - R2;
   localparam logic [31:0] R9          = R2 & R5;
   localparam logic [31:0] R10         = R4 | R6;
   localparam logic [31:0] R11         = R2 ^ R5;
   localparam logic [31:0] SHL_R2      = R2 << 1;
   localparam logic [31:0] SHR_R2      = R2 >> 1;
   localparam logic [31:0] CALL_ADDR   = 32'h2b;
   localparam logic [31:0] CALL_TARGET = 32'h38;   // subroutine entry
   localparam logic [31:0] LOOP_ADDR   = 32'h30;
   localparam logic [31:0] HALT_ADDR   = 32'h3ff;
   localparam logic [31:0] POISON      = 32'h200;

   int unsigned fail_cnt = 0;   // polled by tb_cpu
   logic        halted;
   phase_t      ph;

   assign ph = phase_t'(clk_stat[1:0]);

   function automatic logic [31:0] store_value(input logic [3:0] k);
      case (k)
         4'h0:    return R2;
         4'h1:    return R5;
         4'h2:    return R6;
         4'h3:    return R2;   // sign test passed
         4'h4:    return R9;
         4'h5:    return R10;
         4'h6:    return R11;
         4'h7:    return SHL_R2;
         4'h8:    return SHR_R2;
         4'h9:    return R10;   // mov copy
         4'ha:    return R5;    // reloaded by ld
         4'hb:    return CALL_ADDR + 32'd1;
         default: return 32'hdead_beef;
      endcase
   endfunction

   function automatic logic reg_ok(input logic [3:0] idx, input logic [31:0] val);
      case (idx)
         4'd1:    return val == HALT_ADDR;
         4'd2:    return val == R2;
         4'd3:    return val == R10;
         4'd4:    return val == R5;
         4'd5:    return val == R5;
         4'd6:    return val == R6;
         4'd7:    return val == POISON;
         4'd9:    return val == R9;
         4'd10:   return val == R10;
         4'd11:   return val == R11;
         4'd12:   return val == SHR_R2;
         4'd13:   return val == 32'h7777;
         4'd14:   return val == CALL_ADDR + 32'd1;
         4'd15:   return (val == LOOP_ADDR) || (val == LOOP_ADDR + 32'd1);
         default: return val == '0;   // r0 and r8
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         halted <= 1'b0;
      else if (mbus_wen && mbus_aout == HALT_ADDR)
         halted <= 1'b1;   // program spins from here on
   end

   a_first_fetch: assert property (@(posedge clk)
      rst_n && !$past(rst_n) |-> ph == PH_FETCH && mbus_aout == '0)
      else begin fail_cnt++; $error("first fetch after reset is not at address 0"); end

   a_phase_order: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> clk_stat[1:0] == $past(clk_stat[1:0]) + 2'd1)
      else begin fail_cnt++; $error("phase did not advance in order"); end

   // bit 2 flips once per instruction, as writeback ends
   a_done_toggle: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> clk_stat[2] == ($past(clk_stat[2]) ^ ($past(ph) == PH_WB)))
      else begin fail_cnt++; $error("instruction done toggle out of step with writeback"); end

   a_wen_phase: assert property (@(posedge clk) disable iff (!rst_n)
      mbus_wen |-> ph == PH_MEM)
      else begin fail_cnt++; $error("write strobe outside the memory phase"); end

   a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
      mbus_wen |-> mbus_aout != POISON)
      else begin fail_cnt++; $error("skipped store reached the poison word"); end

   a_store_val: assert property (@(posedge clk) disable iff (!rst_n)
      mbus_wen && mbus_aout[31:4] == 28'h010 |-> mbus_dout == store_value(mbus_aout[3:0]))
      else begin
         fail_cnt++;
         $error("FAILED %0t store to %h carries %h", $time, $sampled(mbus_aout),
                $sampled(mbus_dout));
      end

   // one instruction after fetching the call, fetch is at the target
   a_call_target: assert property (@(posedge clk) disable iff (!rst_n)
      $past(ph, 4) == PH_FETCH && $past(mbus_aout, 4) == CALL_ADDR
      |-> mbus_aout == CALL_TARGET)
      else begin
         fail_cnt++;
         $error("FAILED %0t fetch after call at %h", $time, $sampled(mbus_aout));
      end

   a_final_regs: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> reg_ok(test_rsel, test_reg))
      else begin
         fail_cnt++;
         $error("FAILED %0t r%0d reads %h", $time, $sampled(test_rsel), $sampled(test_reg));
      end

endmodule

bind cpu cpu_assert i_chk
(
   .clk       (clk),
   .rst_n     (rst_n),
   .clk_stat  (clk_stat),
   .mbus_aout (mbus_aout),
   .mbus_dout (mbus_dout),
   .mbus_wen  (mbus_wen),
   .test_rsel (test_rsel),
   .test_reg  (test_reg)
);

// File: dv/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

   localparam int          MEM_WORDS = 1024;
   localparam int          RUN_LIMIT = 4000;   // cycles until the halt store
   localparam logic [31:0] HALT_ADDR = 32'h3ff;

   logic        clk;
   logic        rst_n;
   logic [31:0] mbus_aout;
   logic [31:0] mbus_dout;
   logic [31:0] mbus_din;
   logic        mbus_wen;
   logic [3:0]  test_rsel;
   logic [31:0] test_reg;
   logic [2:0]  clk_stat;

   logic [31:0] mem [MEM_WORDS];

   cpu i_dut
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .mbus_aout (mbus_aout),
      .mbus_dout (mbus_dout),
      .mbus_din  (mbus_din),
      .mbus_wen  (mbus_wen),
      .test_rsel (test_rsel),
      .test_reg  (test_reg),
      .clk_stat  (clk_stat)
   );

   initial clk = 1'b0;

   always #4 clk = ~clk;

   // single port memory, read data in the same cycle
   assign mbus_din = mem[mbus_aout[9:0]];

   always @(posedge clk)
   begin
      if (mbus_wen)
         mem[mbus_aout[9:0]] <= mbus_dout;
   end

   task automatic check_assertions();
      if (i_dut.i_chk.fail_cnt != 0)
      begin
         $display("Regression failed");
         $fatal(1, "an assertion in the checker failed");
      end
   endtask

   initial
   begin
      int cycles;
      bit halted;

      rst_n     = 1'b0;
      test_rsel = '0;
      cycles    = 0;
      halted    = 1'b0;
      $readmemh("dv/prog.hex", mem);
      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      // run until the program stores to the halt word
      while (!halted && cycles < RUN_LIMIT)
      begin
         @(negedge clk);
         cycles++;
         check_assertions();
         halted = mbus_wen && (mbus_aout == HALT_ADDR);
      end

      if (!halted)
      begin
         $display("Regression failed");
         $fatal(1, "no halt store within %0d cycles", RUN_LIMIT);
      end
      else
      begin
         for (int r = 0; r < 16; r++)
         begin
            @(negedge clk);
            check_assertions();
            test_rsel = 4'(r);   // view port sweep
            @(posedge clk);
         end
         @(negedge clk);
         if (i_dut.i_chk.fail_cnt != 0)
         begin
            $display("Regression failed");
            $fatal(1, "an assertion in the checker failed");
         end
         else
         begin
            $display("Regression passed");
            $finish;
         end
      end
   end

endmodule

// File: dv/prog.hex
// instruction words in hex, four per line, starting at the address in the trailing comment
// @ lines move the load address
04100100 04201234 0620ABCD 02210000  // 00 pointer, ldl0 and ldh, first store
04400FF0 07524000 05100101 02510000  // 04 add
07642100 05100102 02610000 04700200  // 08 sub, r7 points at the poison word
72670000 B2670000 05100103 12210000  // 0c c and z tests fail, s test passes
07844100 92670000 52670000 07925200  // 10 sub to zero, and
05100104 02910000 07A46280 07B25300  // 14 or, xor
05100105 02A10000 05100106 02B10000  // 18
07C20400 05100107 02C10000 07C20480  // 1c shl, shr
05100108 02C10000 033A0000 05100109  // 20 mov
02310000 05100101 01410000 0510010A  // 24 ld of the add result
02410000 94F0002B 02670000 08000038  // 28 branch over poison store, call
0510010B 02E10000 041003FF 02010000  // 2c store link, halt store
04F00030                             // 30 spin here
@38
04D07777 03FE0000                    // subroutine, returns through r14

// File: flist.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/phase_sched.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/instr_decode.sv
hdl/cpu.sv
dv/cpu_assert.sv
dv/tb_cpu.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat flist.f)) hdl/cpu_defs.svh

obj_dir/Vtb_cpu: flist.f $(SRCS)
	verilator --binary --assert --top-module tb_cpu -f flist.f -Mdir obj_dir -o Vtb_cpu

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
